/* common/rc4_pkg.sv */
package rc4_pkg;

	localparam int MSG_LEN   = 32; // ciphertext and plaintext length in bytes
	localparam int KEY_BYTES = 3;
	localparam int SBOX_SIZE = 256;

	localparam int AXI_ADDR_W = 12;

	localparam logic [AXI_ADDR_W-1:0] REG_CTRL      = 12'h000; // bit0 starts a search
	localparam logic [AXI_ADDR_W-1:0] REG_STATUS    = 12'h004;
	localparam logic [AXI_ADDR_W-1:0] REG_KEY_FIRST = 12'h008;
	localparam logic [AXI_ADDR_W-1:0] REG_KEY_LAST  = 12'h00c;
	localparam logic [AXI_ADDR_W-1:0] REG_FOUND_KEY = 12'h010;
	localparam logic [AXI_ADDR_W-1:0] CT_WINDOW     = 12'h100; // byte n at +4n, write only
	localparam logic [AXI_ADDR_W-1:0] PT_WINDOW     = 12'h200; // byte n at +4n, read only

	localparam int STATUS_BUSY      = 0;
	localparam int STATUS_FOUND     = 1;
	localparam int STATUS_EXHAUSTED = 2;

endpackage

/* common/byte_mem_if.sv */
`timescale 1ns/1ps

// one byte-wide synchronous memory port, read data two edges after the address
interface byte_mem_if;

	logic [7:0] addr;
	logic [7:0] wrdata;
	logic       wren;
	logic [7:0] rddata;

	modport master (
		output addr,
		output wrdata,
		output wren,
		input  rddata
	);

	modport slave (
		input  addr,
		input  wrdata,
		input  wren,
		output rddata
	);

endinterface

/* hw/byte_ram.sv */
`timescale 1ns/1ps

module byte_ram #(
	parameter int DEPTH = 256
) (
	input logic       clk,
	byte_mem_if.slave mem
);

	localparam int AW = $clog2(DEPTH);

	logic [7:0]    ram [DEPTH];
	logic [AW-1:0] addr_q;

	always_ff @(posedge clk) begin
		if (mem.wren) begin
			ram[mem.addr[AW-1:0]] <= mem.wrdata;
		end
		addr_q     <= mem.addr[AW-1:0]; // first latency stage
		mem.rddata <= ram[addr_q];      // second latency stage
	end

endmodule

/* hw/rc4_core/rc4_key_schedule.sv */
`timescale 1ns/1ps

module rc4_key_schedule import rc4_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        start_i,
	input  logic [23:0] key_i,
	output logic        done_o,
	byte_mem_if.master  mem
);

	typedef enum logic [2:0] {
		S_IDLE, S_FILL, S_RD_I, S_LAT, S_GET_I, S_GET_J, S_WR_I
	} state_t;

	state_t     state, ret_state;
	logic       lat_cnt;
	logic [7:0] i, j, si, sj;
	logic [7:0] key_byte, j_next;

	assign key_byte = key_i[8 * (KEY_BYTES - 1 - (int'(i) % KEY_BYTES)) +: 8]; // byte 0 is the msb
	assign j_next   = j + mem.rddata + key_byte;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state    <= S_IDLE;
			lat_cnt  <= 1'b0;
			done_o   <= 1'b0;
			mem.wren <= 1'b0;
		end else begin
			done_o   <= 1'b0;
			mem.wren <= 1'b0;
			case (state)
				S_IDLE: begin
					if (start_i) begin
						i     <= '0;
						state <= S_FILL;
					end
				end
				S_FILL: begin
					mem.addr   <= i; // s[i] = i
					mem.wrdata <= i;
					mem.wren   <= 1'b1;
					i          <= i + 8'd1;
					if (i == 8'(SBOX_SIZE - 1)) begin
						j     <= '0;
						state <= S_RD_I;
					end
				end
				S_RD_I: begin
					mem.addr  <= i;
					ret_state <= S_GET_I;
					state     <= S_LAT;
				end
				S_LAT: begin // sit out the two ram edges
					lat_cnt <= ~lat_cnt;
					if (lat_cnt) state <= ret_state;
				end
				S_GET_I: begin
					si        <= mem.rddata;
					j         <= j_next;
					mem.addr  <= j_next; // fetch s[j] right away
					ret_state <= S_GET_J;
					state     <= S_LAT;
				end
				S_GET_J: begin
					sj         <= mem.rddata;
					mem.addr   <= j; // s[j] takes old s[i]
					mem.wrdata <= si;
					mem.wren   <= 1'b1;
					state      <= S_WR_I;
				end
				S_WR_I: begin
					mem.addr   <= i; // s[i] takes old s[j]
					mem.wrdata <= sj;
					mem.wren   <= 1'b1;
					i          <= i + 8'd1;
					if (i == 8'(SBOX_SIZE - 1)) begin
						done_o <= 1'b1;
						state  <= S_IDLE;
					end else begin
						state <= S_RD_I;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

/* hw/rc4_core/rc4_keystream_decrypt.sv */
`timescale 1ns/1ps

module rc4_keystream_decrypt import rc4_pkg::*; #(
	parameter int MSG_LEN = rc4_pkg::MSG_LEN
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       start_i,
	input  logic       start_over_i,
	output logic       done_o,
	byte_mem_if.master sbox,
	byte_mem_if.master ct,
	byte_mem_if.master pt,
	output logic       new_char_o,
	output logic [7:0] data_xord_o,
	input  logic       char_compare_i,
	input  logic       char_bad_i
);

	typedef enum logic [3:0] {
		S_IDLE, S_STEP, S_LAT, S_GET_I, S_GET_J, S_WR_I, S_RD_F, S_GET_F, S_OFFER
	} state_t;

	state_t     state, ret_state;
	logic       lat_cnt;
	logic [7:0] i, j, k;
	logic [7:0] si, sj, ct_byte, j_next;

	assign j_next    = j + sbox.rddata;
	assign ct.wren   = 1'b0; // ciphertext is only read here
	assign ct.wrdata = '0;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state      <= S_IDLE;
			lat_cnt    <= 1'b0;
			done_o     <= 1'b0;
			new_char_o <= 1'b0;
			sbox.wren  <= 1'b0;
			pt.wren    <= 1'b0;
		end else begin
			done_o    <= 1'b0;
			sbox.wren <= 1'b0;
			pt.wren   <= 1'b0;
			if (start_over_i) begin // key rejected, drop everything
				state      <= S_IDLE;
				lat_cnt    <= 1'b0;
				new_char_o <= 1'b0;
			end else begin
				case (state)
					S_IDLE: begin
						if (start_i) begin
							i     <= '0;
							j     <= '0;
							k     <= '0;
							state <= S_STEP;
						end
					end
					S_STEP: begin
						if (k == 8'(MSG_LEN)) begin
							done_o <= 1'b1; // whole message passed the checker
							state  <= S_IDLE;
						end else begin
							i         <= i + 8'd1;
							sbox.addr <= i + 8'd1;
							ct.addr   <= k; // ciphertext read runs alongside
							ret_state <= S_GET_I;
							state     <= S_LAT;
						end
					end
					S_LAT: begin
						lat_cnt <= ~lat_cnt;
						if (lat_cnt) state <= ret_state;
					end
					S_GET_I: begin
						si        <= sbox.rddata;
						ct_byte   <= ct.rddata;
						j         <= j_next;
						sbox.addr <= j_next;
						ret_state <= S_GET_J;
						state     <= S_LAT;
					end
					S_GET_J: begin
						sj          <= sbox.rddata;
						sbox.addr   <= j; // swap, first half
						sbox.wrdata <= si;
						sbox.wren   <= 1'b1;
						state       <= S_WR_I;
					end
					S_WR_I: begin
						sbox.addr   <= i;
						sbox.wrdata <= sj;
						sbox.wren   <= 1'b1;
						state       <= S_RD_F;
					end
					S_RD_F: begin
						sbox.addr <= si + sj; // keystream byte s[s[i]+s[j]]
						ret_state <= S_GET_F;
						state     <= S_LAT;
					end
					S_GET_F: begin
						data_xord_o <= sbox.rddata ^ ct_byte;
						new_char_o  <= 1'b1;
						state       <= S_OFFER;
					end
					S_OFFER: begin
						if (char_compare_i) begin
							new_char_o <= 1'b0;
							pt.addr    <= k;
							pt.wrdata  <= data_xord_o;
							pt.wren    <= 1'b1;
							if (char_bad_i) begin
								state <= S_IDLE;
							end else begin
								k     <= k + 8'd1;
								state <= S_STEP;
							end
						end
					end
					default: state <= S_IDLE;
				endcase
			end
		end
	end

endmodule

/* hw/rc4_core/plaintext_checker.sv */
`timescale 1ns/1ps

module plaintext_checker (
	input  logic       clk,
	input  logic       reset,
	input  logic       new_char_i,
	input  logic [7:0] data_i,
	output logic       char_compare_o,
	output logic       char_bad_o
);

	logic       new_char_q;
	logic       pend;
	logic [7:0] data_q;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			new_char_q     <= 1'b0;
			pend           <= 1'b0;
			char_compare_o <= 1'b0;
			char_bad_o     <= 1'b0;
		end else begin
			new_char_q     <= new_char_i;
			char_compare_o <= 1'b0;
			pend           <= 1'b0;
			if (new_char_i && !new_char_q) begin // one answer per offer
				data_q <= data_i;
				pend   <= 1'b1;
			end
			if (pend) begin
				char_compare_o <= 1'b1;
				char_bad_o     <= !((data_q >= 8'h61 && data_q <= 8'h7a) || data_q == 8'h20);
			end
		end
	end

endmodule

/* hw/key_search_ctrl.sv */
`timescale 1ns/1ps

module key_search_ctrl (
	input  logic        clk,
	input  logic        reset,
	input  logic        start_i,
	input  logic [23:0] key_first_i,
	input  logic [23:0] key_last_i,
	output logic        busy_o,
	output logic        found_o,
	output logic        exhausted_o,
	output logic [23:0] found_key_o,
	output logic        ks_start_o,
	input  logic        ks_done_i,
	output logic [23:0] key_o,
	output logic        dec_start_o,
	input  logic        dec_done_i,
	input  logic        char_bad_i,
	input  logic        char_compare_i,
	output logic        start_over_o,
	byte_mem_if.slave   ks_mem,
	byte_mem_if.slave   dec_sbox,
	byte_mem_if.slave   dec_ct,
	byte_mem_if.slave   dec_pt,
	byte_mem_if.slave   reg_ct,
	byte_mem_if.slave   reg_pt,
	byte_mem_if.master  sbox_port,
	byte_mem_if.master  ct_port,
	byte_mem_if.master  pt_port
);

	typedef enum logic [1:0] {S_IDLE, S_SCHED, S_DEC} state_t;

	state_t state;
	logic   sched;

	assign sched = (state == S_SCHED);

	assign sbox_port.addr   = sched ? ks_mem.addr : dec_sbox.addr;
	assign sbox_port.wrdata = sched ? ks_mem.wrdata : dec_sbox.wrdata;
	assign sbox_port.wren   = sched ? ks_mem.wren : dec_sbox.wren;
	assign ks_mem.rddata    = sbox_port.rddata;
	assign dec_sbox.rddata  = sbox_port.rddata;

	assign ct_port.addr   = busy_o ? dec_ct.addr : reg_ct.addr; // software owns idle ports
	assign ct_port.wrdata = busy_o ? dec_ct.wrdata : reg_ct.wrdata;
	assign ct_port.wren   = busy_o ? dec_ct.wren : reg_ct.wren;
	assign dec_ct.rddata  = ct_port.rddata;
	assign reg_ct.rddata  = ct_port.rddata;

	assign pt_port.addr   = busy_o ? dec_pt.addr : reg_pt.addr;
	assign pt_port.wrdata = busy_o ? dec_pt.wrdata : reg_pt.wrdata;
	assign pt_port.wren   = busy_o ? dec_pt.wren : reg_pt.wren;
	assign dec_pt.rddata  = pt_port.rddata;
	assign reg_pt.rddata  = pt_port.rddata;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state        <= S_IDLE;
			busy_o       <= 1'b0;
			found_o      <= 1'b0;
			exhausted_o  <= 1'b0;
			found_key_o  <= '0;
			key_o        <= '0;
			ks_start_o   <= 1'b0;
			dec_start_o  <= 1'b0;
			start_over_o <= 1'b0;
		end else begin
			ks_start_o   <= 1'b0;
			dec_start_o  <= 1'b0;
			start_over_o <= 1'b0;
			case (state)
				S_IDLE: begin
					if (start_i) begin
						found_o     <= 1'b0;
						exhausted_o <= key_first_i > key_last_i; // empty range
						if (key_first_i <= key_last_i) begin
							key_o      <= key_first_i;
							busy_o     <= 1'b1;
							ks_start_o <= 1'b1;
							state      <= S_SCHED;
						end
					end
				end
				S_SCHED: begin
					if (ks_done_i) begin
						dec_start_o <= 1'b1;
						state       <= S_DEC;
					end
				end
				S_DEC: begin
					if (dec_done_i) begin
						found_o     <= 1'b1;
						found_key_o <= key_o;
						busy_o      <= 1'b0;
						state       <= S_IDLE;
					end else if (char_compare_i && char_bad_i) begin
						start_over_o <= 1'b1;
						if (key_o == key_last_i) begin
							exhausted_o <= 1'b1;
							busy_o      <= 1'b0;
							state       <= S_IDLE;
						end else begin
							key_o      <= key_o + 24'd1; // next candidate
							ks_start_o <= 1'b1;
							state      <= S_SCHED;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

/* hw/rc4_cfg_regs.sv */
`timescale 1ns/1ps

module rc4_cfg_regs import rc4_pkg::*; #(
	parameter int MSG_LEN = rc4_pkg::MSG_LEN
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [AXI_ADDR_W-1:0] s_axi_awaddr_i,
	input  logic                  s_axi_awvalid_i,
	output logic                  s_axi_awready_o,
	input  logic [31:0]           s_axi_wdata_i,
	input  logic [3:0]            s_axi_wstrb_i,
	input  logic                  s_axi_wvalid_i,
	output logic                  s_axi_wready_o,
	output logic [1:0]            s_axi_bresp_o,
	output logic                  s_axi_bvalid_o,
	input  logic                  s_axi_bready_i,
	input  logic [AXI_ADDR_W-1:0] s_axi_araddr_i,
	input  logic                  s_axi_arvalid_i,
	output logic                  s_axi_arready_o,
	output logic [31:0]           s_axi_rdata_o,
	output logic [1:0]            s_axi_rresp_o,
	output logic                  s_axi_rvalid_o,
	input  logic                  s_axi_rready_i,
	input  logic                  busy_i,
	input  logic                  found_i,
	input  logic                  exhausted_i,
	input  logic [23:0]           found_key_i,
	output logic                  start_o,
	output logic [23:0]           key_first_o,
	output logic [23:0]           key_last_o,
	byte_mem_if.master            ct,
	byte_mem_if.master            pt
);

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	logic        wr_go, rd_go, rd_pend;
	logic [1:0]  rd_cnt;
	logic [31:0] reg_rdata;
	logic        reg_rd_ok;

	function automatic logic in_win(input logic [AXI_ADDR_W-1:0] a,
			input logic [AXI_ADDR_W-1:0] base);
		return (a >= base) && (a < base + AXI_ADDR_W'(4 * MSG_LEN)) && (a[1:0] == 2'b00);
	endfunction

	assign wr_go = s_axi_awvalid_i && s_axi_wvalid_i && !s_axi_awready_o && !s_axi_bvalid_o;
	assign rd_go = s_axi_arvalid_i && !s_axi_arready_o && !s_axi_rvalid_o && !rd_pend;

	assign pt.wren   = 1'b0; // plaintext window is read only
	assign pt.wrdata = '0;

	always_comb begin
		reg_rdata = '0;
		reg_rd_ok = 1'b1;
		case (s_axi_araddr_i)
			REG_CTRL: reg_rdata = '0;
			REG_STATUS: begin
				reg_rdata[STATUS_BUSY]      = busy_i;
				reg_rdata[STATUS_FOUND]     = found_i;
				reg_rdata[STATUS_EXHAUSTED] = exhausted_i;
			end
			REG_KEY_FIRST: reg_rdata[23:0] = key_first_o;
			REG_KEY_LAST:  reg_rdata[23:0] = key_last_o;
			REG_FOUND_KEY: reg_rdata[23:0] = found_key_i;
			default:       reg_rd_ok = 1'b0; // also pt window while busy
		endcase
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			s_axi_awready_o <= 1'b0;
			s_axi_wready_o  <= 1'b0;
			s_axi_bvalid_o  <= 1'b0;
			s_axi_bresp_o   <= RESP_OKAY;
			start_o         <= 1'b0;
			key_first_o     <= '0;
			key_last_o      <= '0;
			ct.wren         <= 1'b0;
		end else begin
			s_axi_awready_o <= wr_go;
			s_axi_wready_o  <= wr_go;
			start_o         <= 1'b0;
			ct.wren         <= 1'b0;
			if (s_axi_bvalid_o && s_axi_bready_i) s_axi_bvalid_o <= 1'b0;
			if (s_axi_awready_o) begin // address and data taken together
				s_axi_bvalid_o <= 1'b1;
				s_axi_bresp_o  <= RESP_OKAY;
				if (s_axi_wstrb_i != 4'hf) begin
					s_axi_bresp_o <= RESP_SLVERR;
				end else if (in_win(s_axi_awaddr_i, CT_WINDOW)) begin
					if (busy_i) begin
						s_axi_bresp_o <= RESP_SLVERR; // engine owns the ciphertext
					end else begin
						ct.addr   <= 8'((s_axi_awaddr_i - CT_WINDOW) >> 2);
						ct.wrdata <= s_axi_wdata_i[7:0];
						ct.wren   <= 1'b1;
					end
				end else begin
					case (s_axi_awaddr_i)
						REG_CTRL:      start_o <= s_axi_wdata_i[0] && !busy_i;
						REG_KEY_FIRST: key_first_o <= s_axi_wdata_i[23:0];
						REG_KEY_LAST:  key_last_o <= s_axi_wdata_i[23:0];
						default:       s_axi_bresp_o <= RESP_SLVERR;
					endcase
				end
			end
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			s_axi_arready_o <= 1'b0;
			s_axi_rvalid_o  <= 1'b0;
			s_axi_rresp_o   <= RESP_OKAY;
			rd_pend         <= 1'b0;
			rd_cnt          <= '0;
		end else begin
			s_axi_arready_o <= rd_go;
			if (s_axi_rvalid_o && s_axi_rready_i) s_axi_rvalid_o <= 1'b0;
			if (s_axi_arready_o) begin
				if (in_win(s_axi_araddr_i, PT_WINDOW) && !busy_i) begin
					pt.addr <= 8'((s_axi_araddr_i - PT_WINDOW) >> 2);
					rd_pend <= 1'b1;
					rd_cnt  <= '0;
				end else begin
					s_axi_rvalid_o <= 1'b1;
					s_axi_rdata_o  <= reg_rdata;
					s_axi_rresp_o  <= reg_rd_ok ? RESP_OKAY : RESP_SLVERR;
				end
			end
			if (rd_pend) begin // wait out the ram latency
				rd_cnt <= rd_cnt + 2'd1;
				if (rd_cnt == 2'd2) begin
					rd_pend        <= 1'b0;
					s_axi_rvalid_o <= 1'b1;
					s_axi_rdata_o  <= {24'h0, pt.rddata};
					s_axi_rresp_o  <= RESP_OKAY;
				end
			end
		end
	end

endmodule

/* hw/rc4_crack_top.sv */
`timescale 1ns/1ps

module rc4_crack_top import rc4_pkg::*; #(
	parameter int MSG_LEN = rc4_pkg::MSG_LEN
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [AXI_ADDR_W-1:0] s_axi_awaddr_i,
	input  logic                  s_axi_awvalid_i,
	output logic                  s_axi_awready_o,
	input  logic [31:0]           s_axi_wdata_i,
	input  logic [3:0]            s_axi_wstrb_i,
	input  logic                  s_axi_wvalid_i,
	output logic                  s_axi_wready_o,
	output logic [1:0]            s_axi_bresp_o,
	output logic                  s_axi_bvalid_o,
	input  logic                  s_axi_bready_i,
	input  logic [AXI_ADDR_W-1:0] s_axi_araddr_i,
	input  logic                  s_axi_arvalid_i,
	output logic                  s_axi_arready_o,
	output logic [31:0]           s_axi_rdata_o,
	output logic [1:0]            s_axi_rresp_o,
	output logic                  s_axi_rvalid_o,
	input  logic                  s_axi_rready_i,
	output logic                  done_o
);

	logic        start, busy, busy_q, found, exhausted;
	logic [23:0] key_first, key_last, found_key, key;
	logic        ks_start, ks_done, dec_start, dec_done, start_over;
	logic        new_char, char_compare, char_bad;
	logic [7:0]  data_xord;

	byte_mem_if ks_mem ();
	byte_mem_if dec_sbox ();
	byte_mem_if dec_ct ();
	byte_mem_if dec_pt ();
	byte_mem_if reg_ct ();
	byte_mem_if reg_pt ();
	byte_mem_if sbox_port ();
	byte_mem_if ct_port ();
	byte_mem_if pt_port ();

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) busy_q <= 1'b0;
		else        busy_q <= busy;
	end

	assign done_o = busy_q && !busy; // search just ended

	rc4_cfg_regs #(.MSG_LEN(MSG_LEN)) u_regs (
		.clk, .reset,
		.s_axi_awaddr_i, .s_axi_awvalid_i, .s_axi_awready_o,
		.s_axi_wdata_i, .s_axi_wstrb_i, .s_axi_wvalid_i, .s_axi_wready_o,
		.s_axi_bresp_o, .s_axi_bvalid_o, .s_axi_bready_i,
		.s_axi_araddr_i, .s_axi_arvalid_i, .s_axi_arready_o,
		.s_axi_rdata_o, .s_axi_rresp_o, .s_axi_rvalid_o, .s_axi_rready_i,
		.busy_i(busy), .found_i(found), .exhausted_i(exhausted), .found_key_i(found_key),
		.start_o(start), .key_first_o(key_first), .key_last_o(key_last),
		.ct(reg_ct), .pt(reg_pt)
	);

	key_search_ctrl u_ctrl (
		.clk, .reset,
		.start_i(start), .key_first_i(key_first), .key_last_i(key_last),
		.busy_o(busy), .found_o(found), .exhausted_o(exhausted), .found_key_o(found_key),
		.ks_start_o(ks_start), .ks_done_i(ks_done), .key_o(key),
		.dec_start_o(dec_start), .dec_done_i(dec_done),
		.char_bad_i(char_bad), .char_compare_i(char_compare), .start_over_o(start_over),
		.ks_mem, .dec_sbox, .dec_ct, .dec_pt, .reg_ct, .reg_pt,
		.sbox_port, .ct_port, .pt_port
	);

	rc4_key_schedule u_ks (
		.clk, .reset, .start_i(ks_start), .key_i(key), .done_o(ks_done), .mem(ks_mem)
	);

	rc4_keystream_decrypt #(.MSG_LEN(MSG_LEN)) u_dec (
		.clk, .reset, .start_i(dec_start), .start_over_i(start_over), .done_o(dec_done),
		.sbox(dec_sbox), .ct(dec_ct), .pt(dec_pt),
		.new_char_o(new_char), .data_xord_o(data_xord),
		.char_compare_i(char_compare), .char_bad_i(char_bad)
	);

	plaintext_checker u_chk (
		.clk, .reset, .new_char_i(new_char), .data_i(data_xord),
		.char_compare_o(char_compare), .char_bad_o(char_bad)
	);

	byte_ram #(.DEPTH(SBOX_SIZE)) u_sbox_ram (.clk, .mem(sbox_port));
	byte_ram #(.DEPTH(MSG_LEN))   u_ct_ram (.clk, .mem(ct_port));
	byte_ram #(.DEPTH(MSG_LEN))   u_pt_ram (.clk, .mem(pt_port));

endmodule

/* verification/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 16
) (
	output logic clk_o,
	output logic reset_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

	initial begin
		reset_o = 1'b0; // active low, held from time zero
		repeat (RESET_CYCLES) @(posedge clk_o);
		reset_o <= 1'b1;
	end

endmodule

/* verification/tb_rc4_crack.sv */
`timescale 1ns/1ps

module tb_rc4_crack import rc4_pkg::*; ;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	typedef struct packed {
		logic [31:0] seed;       // mixed into the plaintext draw
		logic [23:0] true_key;
		logic [23:0] key_first;
		logic [23:0] key_last;
		logic        busy_probe; // write ct while the search runs
		logic        exp_found;
		logic        exp_exhausted;
	} test_row_t;

	localparam int NUM_TESTS = 4;
	localparam test_row_t TESTS [NUM_TESTS] = '{
		'{32'h0000_0011, 24'h1a2b3c, 24'h1a2b3a, 24'h1a2b3f, 1'b0, 1'b1, 1'b0},
		'{32'h0000_0022, 24'h000102, 24'h000100, 24'h000101, 1'b0, 1'b0, 1'b1},
		'{32'h0000_0033, 24'hc0ffee, 24'hc0ffe9, 24'hc0fff0, 1'b1, 1'b1, 1'b0},
		'{32'h0000_0044, 24'h7f0001, 24'h7f0001, 24'h7f0001, 1'b0, 1'b1, 1'b0}
	};

	logic                  clk, reset, done;
	logic [AXI_ADDR_W-1:0] awaddr, araddr;
	logic                  awvalid, awready, wvalid, wready, bvalid, bready;
	logic                  arvalid, arready, rvalid, rready;
	logic [31:0]           wdata, rdata;
	logic [3:0]            wstrb;
	logic [1:0]            bresp, rresp;

	logic [7:0] pt_model [MSG_LEN];
	logic [7:0] ct_model [MSG_LEN];
	int         cycles = 0;
	int         cycle_limit = 5000;
	int         done_count = 0;

	clk_gen #(.PERIOD_NS(20), .RESET_CYCLES(16)) u_clk_gen (.clk_o(clk), .reset_o(reset));

	rc4_crack_top #(.MSG_LEN(MSG_LEN)) u_dut (
		.clk, .reset,
		.s_axi_awaddr_i(awaddr), .s_axi_awvalid_i(awvalid), .s_axi_awready_o(awready),
		.s_axi_wdata_i(wdata), .s_axi_wstrb_i(wstrb), .s_axi_wvalid_i(wvalid),
		.s_axi_wready_o(wready), .s_axi_bresp_o(bresp), .s_axi_bvalid_o(bvalid),
		.s_axi_bready_i(bready), .s_axi_araddr_i(araddr), .s_axi_arvalid_i(arvalid),
		.s_axi_arready_o(arready), .s_axi_rdata_o(rdata), .s_axi_rresp_o(rresp),
		.s_axi_rvalid_o(rvalid), .s_axi_rready_i(rready), .done_o(done)
	);

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout: search did not finish within %0d cycles", cycle_limit);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	always @(posedge clk) begin
		if (done) done_count = done_count + 1; // one pulse per finished search
	end

	// address and data go out together and the response is taken on bvalid
	task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		@(posedge clk);
		awaddr  <= addr;
		wdata   <= data;
		wstrb   <= 4'hf;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		bready  <= 1'b1;
		@(posedge clk);
		while (!awready) @(posedge clk);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		while (!bvalid) @(posedge clk);
		resp = bresp;
		bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		@(posedge clk);
		araddr  <= addr;
		arvalid <= 1'b1;
		rready  <= 1'b1;
		@(posedge clk);
		while (!arready) @(posedge clk);
		arvalid <= 1'b0;
		while (!rvalid) @(posedge clk);
		data = rdata;
		resp = rresp;
		rready <= 1'b0;
	endtask

	// reference RC4 over the whole message with key byte 0 as the msb
	task automatic rc4_encrypt(input logic [23:0] key);
		logic [7:0] s [256];
		logic [7:0] kb [3];
		logic [7:0] i, j, t;
		int         n;
		kb[0] = key[23:16];
		kb[1] = key[15:8];
		kb[2] = key[7:0];
		for (n = 0; n < 256; n++) s[n] = 8'(n);
		j = 8'd0;
		for (n = 0; n < 256; n++) begin
			j = j + s[n] + kb[n % 3];
			t = s[n];
			s[n] = s[j];
			s[j] = t;
		end
		i = 8'd0;
		j = 8'd0;
		for (n = 0; n < MSG_LEN; n++) begin
			i = i + 8'd1;
			j = j + s[i];
			t = s[i];
			s[i] = s[j];
			s[j] = t;
			ct_model[n] = pt_model[n] ^ s[8'(s[i] + s[j])];
		end
	endtask

	initial begin
		test_row_t   row;
		logic [31:0] data;
		logic [31:0] exp_status;
		logic [1:0]  resp;
		int unsigned r;
		int          t, n, errors, pass_count, fail_count;
		int          done_before;
		awaddr  <= '0;
		awvalid <= 1'b0;
		wdata   <= '0;
		wstrb   <= '0;
		wvalid  <= 1'b0;
		bready  <= 1'b0;
		araddr  <= '0;
		arvalid <= 1'b0;
		rready  <= 1'b0;
		pass_count = 0;
		fail_count = 0;
		for (t = 0; t < NUM_TESTS; t++) begin
			cycle_limit = cycle_limit + 3000 * int'(TESTS[t].key_last - TESTS[t].key_first + 1);
		end
		void'($urandom(32));
		@(posedge reset);
		repeat (2) @(posedge clk);

		errors = 0; // idle state straight after reset
		axi_read(REG_STATUS, data, resp);
		if (data != 32'h0 || resp != RESP_OKAY) begin
			$display("Mismatch reset STATUS: got 0x%0h resp 0x%0h expected 0x0", data, resp);
			errors++;
		end
		axi_read(PT_WINDOW, data, resp);
		if (resp != RESP_OKAY) begin
			$display("Mismatch reset PT_WINDOW rresp: got 0x%0h expected 0x0", resp);
			errors++;
		end
		if (done_count != 0) begin
			$display("Mismatch reset done_o pulses: got 0x%0h expected 0x0", done_count);
			errors++;
		end
		$display("test reset: %s", errors == 0 ? "pass" : "fail");
		if (errors == 0) pass_count++;
		else fail_count++;

		for (t = 0; t < NUM_TESTS; t++) begin
			row = TESTS[t];
			errors = 0;
			for (n = 0; n < MSG_LEN; n++) begin
				r = ($urandom() ^ row.seed) % 27;
				pt_model[n] = (r == 26) ? 8'h20 : 8'h61 + 8'(r); // lowercase or space
			end
			rc4_encrypt(row.true_key);
			for (n = 0; n < MSG_LEN; n++) begin
				axi_write(CT_WINDOW + AXI_ADDR_W'(4 * n), {24'h0, ct_model[n]}, resp);
				if (resp != RESP_OKAY) begin
					$display("Mismatch test %0d CT write %0d bresp: got 0x%0h expected 0x%0h",
						t, n, resp, RESP_OKAY);
					errors++;
				end
			end
			axi_write(REG_KEY_FIRST, {8'h0, row.key_first}, resp);
			axi_write(REG_KEY_LAST, {8'h0, row.key_last}, resp);
			done_before = done_count;
			axi_write(REG_CTRL, 32'h1, resp);
			if (row.busy_probe) begin
				axi_read(REG_STATUS, data, resp);
				if (!data[STATUS_BUSY]) begin
					$display("test %0d: search was not running when the probe write came", t);
					errors++;
				end
				axi_write(CT_WINDOW, {24'h0, ~ct_model[0]}, resp); // must be dropped
				if (resp != RESP_SLVERR) begin
					$display("Mismatch test %0d busy CT bresp: got 0x%0h expected 0x%0h",
						t, resp, RESP_SLVERR);
					errors++;
				end
			end
			axi_read(REG_STATUS, data, resp);
			while (data[STATUS_BUSY]) axi_read(REG_STATUS, data, resp);
			exp_status = '0;
			exp_status[STATUS_FOUND]     = row.exp_found;
			exp_status[STATUS_EXHAUSTED] = row.exp_exhausted;
			if (data != exp_status) begin
				$display("Mismatch test %0d STATUS: got 0x%0h expected 0x%0h",
					t, data, exp_status);
				errors++;
			end
			if (done_count != done_before + 1) begin
				$display("Mismatch test %0d done_o pulses: got 0x%0h expected 0x1",
					t, done_count - done_before);
				errors++;
			end
			if (row.exp_found) begin
				axi_read(REG_FOUND_KEY, data, resp);
				if (data != {8'h0, row.true_key}) begin
					$display("Mismatch test %0d FOUND_KEY: got 0x%0h expected 0x%0h",
						t, data, row.true_key);
					errors++;
				end
				for (n = 0; n < MSG_LEN; n++) begin
					axi_read(PT_WINDOW + AXI_ADDR_W'(4 * n), data, resp);
					if (resp != RESP_OKAY || data != {24'h0, pt_model[n]}) begin
						$display("Mismatch test %0d PT[%0d]: got 0x%0h resp 0x%0h expected 0x%0h",
							t, n, data, resp, pt_model[n]);
						errors++;
					end
				end
			end
			$display("test %0d keys 0x%06h..0x%06h: %s", t, row.key_first, row.key_last,
				errors == 0 ? "pass" : "fail");
			if (errors == 0) pass_count++;
			else fail_count++;
		end

		$display("tests: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

/* rc4_crack.f */
common/rc4_pkg.sv
common/byte_mem_if.sv
hw/byte_ram.sv
hw/rc4_core/rc4_key_schedule.sv
hw/rc4_core/rc4_keystream_decrypt.sv
hw/rc4_core/plaintext_checker.sv
hw/key_search_ctrl.sv
hw/rc4_cfg_regs.sv
hw/rc4_crack_top.sv
verification/clk_gen.sv
verification/tb_rc4_crack.sv

/* Makefile */
SIM := obj_dir/Vtb_rc4_crack

.PHONY: all run clean

all: run

# rebuilt only when the file list or one of the sources it names changes
$(SIM): rc4_crack.f $(shell cat rc4_crack.f)
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_rc4_crack -f rc4_crack.f

# the run fails unless the pass message shows up in the simulator output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
